/* logic/arcade_input_pkg.sv */
package arcade_input_pkg;

	typedef logic [7:0] scancode_t;   // ps/2 set-2 make code
	typedef logic [7:0] joy_t;
	typedef logic [7:0] dip_t;
	typedef logic [3:0] apb_addr_t;
	typedef logic [31:0] apb_data_t;

	// held buttons, value doubles as index into the held vector
	typedef enum logic [3:0] {
		BTN_UP,
		BTN_DOWN,
		BTN_LEFT,
		BTN_RIGHT,
		BTN_COIN,
		BTN_START1,
		BTN_START2,
		BTN_FIRE1,
		BTN_FIRE2
	} btn_id_t;

	localparam int BTN_COUNT = 9;

	typedef struct packed {
		btn_id_t btn;
		logic    pressed;
	} key_event_t;

	typedef struct packed {
		logic coin;
		logic start1;
		logic start2;
		logic fire;
		logic bomb;
		logic left;
		logic right;
		logic up;
		logic down;
	} game_inputs_t;

	typedef struct packed {
		logic       soft_reset;
		logic       rotate;
		logic       overlay_on;
		logic [1:0] scanlines;
		dip_t       dip;
	} core_cfg_t;

	// joystick bit positions
	localparam int JOY_RIGHT = 0;
	localparam int JOY_LEFT  = 1;
	localparam int JOY_DOWN  = 2;
	localparam int JOY_UP    = 3;
	localparam int JOY_FIRE1 = 4;
	localparam int JOY_FIRE2 = 5;

	localparam apb_addr_t REG_CTRL   = 4'h0;
	localparam apb_addr_t REG_DIP    = 4'h4;
	localparam apb_addr_t REG_STATUS = 4'h8;

	localparam scancode_t SC_UP     = 8'h75;
	localparam scancode_t SC_DOWN   = 8'h72;
	localparam scancode_t SC_LEFT   = 8'h6B;
	localparam scancode_t SC_RIGHT  = 8'h74;
	localparam scancode_t SC_ESC    = 8'h76; // coin
	localparam scancode_t SC_F1     = 8'h05; // start1
	localparam scancode_t SC_F2     = 8'h06; // start2
	localparam scancode_t SC_SPACE  = 8'h29; // fire1
	localparam scancode_t SC_ALT    = 8'h11; // fire2

endpackage

/* logic/key_event_decoder.sv */
`timescale 1ns/1ps

module key_event_decoder (
	input  logic                          clk_mist,
	input  logic                          rst_n,
	input  logic                          key_strobe,
	input  arcade_input_pkg::scancode_t   key_code,
	input  logic                          key_pressed,
	output logic                          event_valid,
	output arcade_input_pkg::key_event_t  key_event
);
	import arcade_input_pkg::*;

	btn_id_t btn_id;
	logic    code_known;

	// scancode lookup, anything not listed is ignored
	always_comb begin
		code_known = 1'b1;
		btn_id     = BTN_UP;
		case (key_code)
			SC_UP:    btn_id = BTN_UP;
			SC_DOWN:  btn_id = BTN_DOWN;
			SC_LEFT:  btn_id = BTN_LEFT;
			SC_RIGHT: btn_id = BTN_RIGHT;
			SC_ESC:   btn_id = BTN_COIN;
			SC_F1:    btn_id = BTN_START1;
			SC_F2:    btn_id = BTN_START2;
			SC_SPACE: btn_id = BTN_FIRE1;
			SC_ALT:   btn_id = BTN_FIRE2;
			default:  code_known = 1'b0;
		endcase
	end

	always_ff @(posedge clk_mist or negedge rst_n) begin
		if (!rst_n) begin
			event_valid <= 1'b0;
		end else begin
			event_valid <= key_strobe && code_known; // one-cycle pulse
		end
	end

	// payload only, qualified by event_valid
	always_ff @(posedge clk_mist) begin
		if (key_strobe && code_known) begin
			key_event.btn     <= btn_id;
			key_event.pressed <= key_pressed;
		end
	end

endmodule

/* logic/key_event_fifo.sv */
`timescale 1ns/1ps

module key_event_fifo #(
	parameter int FIFO_DEPTH = 4
) (
	input  logic                          clk_mist,
	input  logic                          rst_n,
	input  logic                          event_valid,
	input  arcade_input_pkg::key_event_t  key_event,
	input  logic                          pop,
	output logic                          not_empty,
	output arcade_input_pkg::key_event_t  head_event,
	output logic                          overflow
);
	import arcade_input_pkg::*;

	localparam int PTR_W = $clog2(FIFO_DEPTH);

	key_event_t       mem [FIFO_DEPTH];
	logic [PTR_W-1:0] wr_ptr;
	logic [PTR_W-1:0] rd_ptr;
	logic [PTR_W:0]   count;   // one extra bit so full is distinct from empty
	logic             full;
	logic             push;
	logic             pull;

	assign full       = (count == FIFO_DEPTH[PTR_W:0]);
	assign not_empty  = (count != '0);
	assign head_event = mem[rd_ptr];

	assign push     = event_valid && !full;
	assign pull     = pop && not_empty;
	assign overflow = event_valid && full; // dropped event

	always_ff @(posedge clk_mist or negedge rst_n) begin
		if (!rst_n) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (push)
				wr_ptr <= wr_ptr + 1'b1; // wraps, depth is a power of two
			if (pull)
				rd_ptr <= rd_ptr + 1'b1;
			case ({push, pull})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

	always_ff @(posedge clk_mist) begin
		if (push)
			mem[wr_ptr] <= key_event;
	end

endmodule

/* logic/control_mapper.sv */
`timescale 1ns/1ps

module control_mapper (
	input  logic                          clk_mist,
	input  logic                          rst_n,
	input  logic                          not_empty,
	input  arcade_input_pkg::key_event_t  head_event,
	input  arcade_input_pkg::core_cfg_t   core_cfg,
	input  arcade_input_pkg::joy_t        joystick_0,
	input  arcade_input_pkg::joy_t        joystick_1,
	output logic                          pop,
	output arcade_input_pkg::game_inputs_t game_inputs
);
	import arcade_input_pkg::*;

	logic [BTN_COUNT-1:0] held;
	logic [BTN_COUNT-1:0] held_nxt;
	joy_t                 joy_any;
	game_inputs_t         inputs_nxt;

	// drain one event per cycle unless the core is held in reset
	assign pop = not_empty && !core_cfg.soft_reset;

	assign joy_any = joystick_0 | joystick_1;

	always_comb begin
		held_nxt = held;
		if (pop)
			held_nxt[head_event.btn] = head_event.pressed;

		inputs_nxt.coin   = held_nxt[BTN_COIN];
		inputs_nxt.start1 = held_nxt[BTN_START1];
		inputs_nxt.start2 = held_nxt[BTN_START2];
		inputs_nxt.fire   = held_nxt[BTN_FIRE1] | joy_any[JOY_FIRE1];
		inputs_nxt.bomb   = held_nxt[BTN_FIRE2] | joy_any[JOY_FIRE2];

		if (core_cfg.rotate) begin
			// upright, straight through
			inputs_nxt.up    = held_nxt[BTN_UP]    | joy_any[JOY_UP];
			inputs_nxt.down  = held_nxt[BTN_DOWN]  | joy_any[JOY_DOWN];
			inputs_nxt.left  = held_nxt[BTN_LEFT]  | joy_any[JOY_LEFT];
			inputs_nxt.right = held_nxt[BTN_RIGHT] | joy_any[JOY_RIGHT];
		end else begin
			// cabinet orientation, screen turned a quarter
			inputs_nxt.left  = held_nxt[BTN_UP]    | joy_any[JOY_UP];
			inputs_nxt.right = held_nxt[BTN_DOWN]  | joy_any[JOY_DOWN];
			inputs_nxt.up    = held_nxt[BTN_RIGHT] | joy_any[JOY_RIGHT];
			inputs_nxt.down  = held_nxt[BTN_LEFT]  | joy_any[JOY_LEFT];
		end
	end

	// output sampled from next state so a popped key shows the same edge
	always_ff @(posedge clk_mist or negedge rst_n) begin
		if (!rst_n) begin
			held        <= '0;
			game_inputs <= '0;
		end else if (!core_cfg.soft_reset) begin
			held        <= held_nxt;
			game_inputs <= inputs_nxt;
		end
	end

endmodule

/* logic/core_config_regs.sv */
`timescale 1ns/1ps

module core_config_regs (
	input  logic                         clk_mist,
	input  logic                         rst_n,
	input  logic                         psel,
	input  logic                         penable,
	input  logic                         pwrite,
	input  arcade_input_pkg::apb_addr_t  paddr,
	input  arcade_input_pkg::apb_data_t  pwdata,
	input  logic                         overflow,
	output arcade_input_pkg::apb_data_t  prdata,
	output arcade_input_pkg::core_cfg_t  core_cfg
);
	import arcade_input_pkg::*;

	logic       soft_reset_q;
	logic       rotate_q;
	logic       overlay_off_q;  // stored inverted so reset means overlay on
	logic [1:0] scanlines_q;
	dip_t       dip_q;
	logic       overflow_q;     // sticky
	logic       wr_en;

	assign wr_en = psel && penable && pwrite;

	always_ff @(posedge clk_mist or negedge rst_n) begin
		if (!rst_n) begin
			soft_reset_q  <= 1'b0;
			rotate_q      <= 1'b0;
			overlay_off_q <= 1'b0;
			scanlines_q   <= 2'b00;
			dip_q         <= '0;
			overflow_q    <= 1'b0;
		end else begin
			if (wr_en && paddr == REG_CTRL) begin
				soft_reset_q  <= pwdata[0];
				rotate_q      <= pwdata[1];
				overlay_off_q <= pwdata[2];
				scanlines_q   <= pwdata[4:3];
			end
			if (wr_en && paddr == REG_DIP)
				dip_q <= pwdata[7:0];
			// a new overflow beats a clear in the same cycle
			if (overflow)
				overflow_q <= 1'b1;
			else if (wr_en && paddr == REG_STATUS && pwdata[0])
				overflow_q <= 1'b0;
		end
	end

	always_comb begin
		prdata = '0;
		if (psel && !pwrite) begin
			case (paddr)
				REG_CTRL:   prdata[4:0] = {scanlines_q, overlay_off_q, rotate_q, soft_reset_q};
				REG_DIP:    prdata[7:0] = dip_q;
				REG_STATUS: prdata[0]   = overflow_q;
				default:    prdata      = '0; // unmapped
			endcase
		end
	end

	assign core_cfg = '{
		soft_reset: soft_reset_q,
		rotate:     rotate_q,
		overlay_on: !overlay_off_q,
		scanlines:  scanlines_q,
		dip:        dip_q
	};

endmodule

/* logic/arcade_input_top.sv */
`timescale 1ns/1ps

module arcade_input_top #(
	parameter int FIFO_DEPTH = 4  // power of two
) (
	input  logic                           clk_mist,
	input  logic                           rst_n,
	input  logic                           key_strobe,
	input  arcade_input_pkg::scancode_t    key_code,
	input  logic                           key_pressed,
	input  arcade_input_pkg::joy_t         joystick_0,
	input  arcade_input_pkg::joy_t         joystick_1,
	input  logic                           psel,
	input  logic                           penable,
	input  logic                           pwrite,
	input  arcade_input_pkg::apb_addr_t    paddr,
	input  arcade_input_pkg::apb_data_t    pwdata,
	output arcade_input_pkg::apb_data_t    prdata,
	output arcade_input_pkg::game_inputs_t game_inputs,
	output arcade_input_pkg::core_cfg_t    core_cfg
);
	import arcade_input_pkg::*;

	logic       event_valid;
	key_event_t key_event;
	logic       not_empty;
	key_event_t head_event;
	logic       pop;
	logic       overflow;

	key_event_decoder key_event_decoder_inst (
		.clk_mist    (clk_mist),
		.rst_n       (rst_n),
		.key_strobe  (key_strobe),
		.key_code    (key_code),
		.key_pressed (key_pressed),
		.event_valid (event_valid),
		.key_event   (key_event)
	);

	key_event_fifo #(
		.FIFO_DEPTH (FIFO_DEPTH)
	) key_event_fifo_inst (
		.clk_mist    (clk_mist),
		.rst_n       (rst_n),
		.event_valid (event_valid),
		.key_event   (key_event),
		.pop         (pop),
		.not_empty   (not_empty),
		.head_event  (head_event),
		.overflow    (overflow)
	);

	control_mapper control_mapper_inst (
		.clk_mist    (clk_mist),
		.rst_n       (rst_n),
		.not_empty   (not_empty),
		.head_event  (head_event),
		.core_cfg    (core_cfg),
		.joystick_0  (joystick_0),
		.joystick_1  (joystick_1),
		.pop         (pop),
		.game_inputs (game_inputs)
	);

	core_config_regs core_config_regs_inst (
		.clk_mist (clk_mist),
		.rst_n    (rst_n),
		.psel     (psel),
		.penable  (penable),
		.pwrite   (pwrite),
		.paddr    (paddr),
		.pwdata   (pwdata),
		.overflow (overflow),
		.prdata   (prdata),
		.core_cfg (core_cfg)
	);

endmodule

/* dv/arcade_input_tb.sv */
`timescale 1ns/1ps

module arcade_input_tb;
	import arcade_input_pkg::*;

	localparam int FIFO_DEPTH = 4;
	// fire2, fire1, start2, start1, coin, right, left, down, up
	localparam logic [71:0] KEY_CODES = {8'h11, 8'h29, 8'h06, 8'h05, 8'h76,
		8'h74, 8'h6B, 8'h72, 8'h75};

	typedef enum logic [2:0] {ACT_KEY, ACT_JOY, ACT_WR, ACT_RD, ACT_DRAIN} act_t;
	typedef struct packed {
		act_t      kind;
		apb_data_t a;    // scancode, address or joystick 0
		apb_data_t b;    // pressed flag, write data or joystick 1
		apb_data_t exp;  // expected read data
	} entry_t;

	logic           clk_mist;
	logic           rst_n;
	logic           key_strobe;
	scancode_t      key_code;
	logic           key_pressed;
	joy_t           joystick_0;
	joy_t           joystick_1;
	logic           psel;
	logic           penable;
	logic           pwrite;
	apb_addr_t      paddr;
	apb_data_t      pwdata;
	apb_data_t      prdata;
	game_inputs_t   game_inputs;
	core_cfg_t      core_cfg;

	// reference model of the held keys and registers
	logic [8:0]     m_held;
	joy_t           m_joy0;
	joy_t           m_joy1;
	logic [4:0]     m_ctrl;
	dip_t           m_dip;
	game_inputs_t   m_out;
	logic [4:0]     m_queue[$];  // {button index, pressed}

	entry_t         table_q[$];
	int             table_len = 0;
	int             n_pass;
	int             n_fail;
	logic           entry_ok;
	logic [15:0]    lfsr;

	arcade_input_top #(
		.FIFO_DEPTH (FIFO_DEPTH)
	) arcade_input_top_inst (
		.clk_mist    (clk_mist),
		.rst_n       (rst_n),
		.key_strobe  (key_strobe),
		.key_code    (key_code),
		.key_pressed (key_pressed),
		.joystick_0  (joystick_0),
		.joystick_1  (joystick_1),
		.psel        (psel),
		.penable     (penable),
		.pwrite      (pwrite),
		.paddr       (paddr),
		.pwdata      (pwdata),
		.prdata      (prdata),
		.game_inputs (game_inputs),
		.core_cfg    (core_cfg)
	);

	initial begin
		clk_mist = 1'b0;
		forever #5 clk_mist = ~clk_mist;
	end

	function automatic int btn_index(scancode_t code);
		case (code)
			8'h75:   return 0;
			8'h72:   return 1;
			8'h6B:   return 2;
			8'h74:   return 3;
			8'h76:   return 4;
			8'h05:   return 5;
			8'h06:   return 6;
			8'h29:   return 7;
			8'h11:   return 8;
			default: return -1;
		endcase
	endfunction

	function automatic game_inputs_t expected_inputs();
		joy_t         j;
		game_inputs_t g;
		j        = m_joy0 | m_joy1;
		g.coin   = m_held[4];
		g.start1 = m_held[5];
		g.start2 = m_held[6];
		g.fire   = m_held[7] | j[4];
		g.bomb   = m_held[8] | j[5];
		if (m_ctrl[1]) begin
			g.up    = m_held[0] | j[3];
			g.down  = m_held[1] | j[2];
			g.left  = m_held[2] | j[1];
			g.right = m_held[3] | j[0];
		end else begin
			g.left  = m_held[0] | j[3]; // cabinet turned a quarter
			g.right = m_held[1] | j[2];
			g.up    = m_held[3] | j[0];
			g.down  = m_held[2] | j[1];
		end
		return g;
	endfunction

	// x^16 + x^14 + x^13 + x^11
	function automatic logic lfsr_bit();
		logic fb;
		fb   = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];
		lfsr = {lfsr[14:0], fb};
		return fb;
	endfunction

	task automatic next_cycle();
		@(posedge clk_mist);
		#1;
	endtask

	task automatic check_inputs(string name, game_inputs_t exp, game_inputs_t act);
		if (act !== exp) begin
			$display("FAILED %0d ns: %s expected %h got %h", $time, name, exp, act);
			entry_ok = 1'b0;
		end
	endtask

	task automatic check_word(string name, apb_data_t exp, apb_data_t act);
		if (act !== exp) begin
			$display("FAILED %0d ns: %s expected %h got %h", $time, name, exp, act);
			entry_ok = 1'b0;
		end
	endtask

	task automatic check_cfg(string name, core_cfg_t exp, core_cfg_t act);
		if (act !== exp) begin
			$display("FAILED %0d ns: %s expected %h got %h", $time, name, exp, act);
			entry_ok = 1'b0;
		end
	endtask

	task automatic apb_write(apb_addr_t addr, apb_data_t data);
		psel   = 1'b1;
		pwrite = 1'b1;
		paddr  = addr;
		pwdata = data;
		next_cycle();
		penable = 1'b1;
		next_cycle(); // write lands on this edge
		psel    = 1'b0;
		penable = 1'b0;
		pwrite  = 1'b0;
	endtask

	task automatic apb_read(apb_addr_t addr, output apb_data_t data);
		psel   = 1'b1;
		pwrite = 1'b0;
		paddr  = addr;
		next_cycle();
		penable = 1'b1;
		#4 data = prdata; // mid access phase
		next_cycle();
		psel    = 1'b0;
		penable = 1'b0;
	endtask

	task automatic add_entry(act_t kind, apb_data_t a, apb_data_t b, apb_data_t exp);
		entry_t e;
		e.kind = kind;
		e.a    = a;
		e.b    = b;
		e.exp  = exp;
		table_q.push_back(e);
	endtask

	task automatic build_table();
		add_entry(ACT_JOY, 0, 0, 0);
		add_entry(ACT_RD, 'h0, 0, 0);
		add_entry(ACT_RD, 'h4, 0, 0);
		add_entry(ACT_RD, 'h8, 0, 0);
		for (int i = 0; i < 9; i++) begin
			add_entry(ACT_KEY, KEY_CODES[i*8 +: 8], 1, 0);
			add_entry(ACT_KEY, KEY_CODES[i*8 +: 8], 0, 0);
		end
		add_entry(ACT_KEY, 'h1C, 1, 0); // not mapped
		add_entry(ACT_KEY, 'h75, 1, 0);
		add_entry(ACT_WR, 'h0, 'h2, 0);
		add_entry(ACT_KEY, 'h75, 0, 0);
		add_entry(ACT_JOY, 'h01, 'h00, 0);
		add_entry(ACT_JOY, 'h00, 'h18, 0);
		add_entry(ACT_WR, 'h0, 'h0, 0);
		add_entry(ACT_JOY, 'h04, 'h20, 0);
		add_entry(ACT_KEY, 'h6B, 1, 0);
		add_entry(ACT_JOY, 'h02, 'h02, 0); // same direction on key and both sticks
		add_entry(ACT_KEY, 'h6B, 0, 0);
		add_entry(ACT_JOY, 0, 0, 0);
		add_entry(ACT_WR, 'h0, 'h1C, 0);
		add_entry(ACT_RD, 'h0, 0, 'h1C);
		add_entry(ACT_WR, 'h4, 'hA5, 0);
		add_entry(ACT_RD, 'h4, 0, 'hA5);
		add_entry(ACT_WR, 'h4, 'hFFFF_FF5A, 0);
		add_entry(ACT_RD, 'h4, 0, 'h5A);
		add_entry(ACT_RD, 'hC, 0, 0);
		add_entry(ACT_RD, 'h2, 0, 0);
		add_entry(ACT_WR, 'h0, 'h0, 0);
		add_entry(ACT_KEY, 'h29, 1, 0);
		add_entry(ACT_WR, 'h0, 'h1, 0);
		// last two of six events overflow the four deep queue
		add_entry(ACT_KEY, 'h75, 1, 0);
		add_entry(ACT_KEY, 'h75, 0, 0);
		add_entry(ACT_KEY, 'h76, 1, 0);
		add_entry(ACT_KEY, 'h06, 1, 0);
		add_entry(ACT_KEY, 'h05, 1, 0);
		add_entry(ACT_KEY, 'h72, 1, 0);
		add_entry(ACT_RD, 'h8, 0, 'h1);
		add_entry(ACT_WR, 'h0, 'h0, 0);
		add_entry(ACT_DRAIN, 0, 0, 0);
		add_entry(ACT_WR, 'h8, 'h1, 0);
		add_entry(ACT_RD, 'h8, 0, 0);
		add_entry(ACT_KEY, 'h29, 0, 0);
		add_entry(ACT_KEY, 'h76, 0, 0);
		add_entry(ACT_KEY, 'h06, 0, 0);
	endtask

	task automatic run_entry(entry_t e);
		int        idx;
		int        waited;
		logic      drained;
		logic [4:0] ev;
		apb_data_t rd;
		core_cfg_t exp_cfg;
		case (e.kind)
			ACT_KEY: begin
				key_code    = e.a[7:0];
				key_pressed = e.b[0];
				key_strobe  = 1'b1;
				next_cycle();
				key_strobe = 1'b0;
				next_cycle();
				check_inputs("game_inputs", m_out, game_inputs); // event still queued
				next_cycle(); // popped and applied on this edge
				idx = btn_index(e.a[7:0]);
				if (idx >= 0 && m_ctrl[0]) begin
					if (m_queue.size() < FIFO_DEPTH)
						m_queue.push_back({idx[3:0], e.b[0]});
				end else if (idx >= 0) begin
					m_held[idx] = e.b[0];
				end
				if (!m_ctrl[0])
					m_out = expected_inputs();
				check_inputs("game_inputs", m_out, game_inputs);
			end
			ACT_JOY: begin
				joystick_0 = e.a[7:0];
				joystick_1 = e.b[7:0];
				next_cycle();
				m_joy0 = e.a[7:0];
				m_joy1 = e.b[7:0];
				if (!m_ctrl[0])
					m_out = expected_inputs();
				check_inputs("game_inputs", m_out, game_inputs);
			end
			ACT_WR: begin
				apb_write(e.a[3:0], e.b);
				drained = 1'b0;
				if (e.a[3:0] == 4'h0) begin
					if (m_ctrl[0] && !e.b[0] && m_queue.size() > 0) begin
						drained = 1'b1; // mapper empties the queue in order
						while (m_queue.size() > 0) begin
							ev = m_queue.pop_front();
							m_held[ev[4:1]] = ev[0];
						end
					end
					m_ctrl = e.b[4:0];
				end
				if (e.a[3:0] == 4'h4)
					m_dip = e.b[7:0];
				exp_cfg.soft_reset = m_ctrl[0];
				exp_cfg.rotate     = m_ctrl[1];
				exp_cfg.overlay_on = !m_ctrl[2];
				exp_cfg.scanlines  = m_ctrl[4:3];
				exp_cfg.dip        = m_dip;
				check_cfg("core_cfg", exp_cfg, core_cfg);
				next_cycle();
				if (!m_ctrl[0])
					m_out = expected_inputs();
				if (!drained)
					check_inputs("game_inputs", m_out, game_inputs);
			end
			ACT_RD: begin
				apb_read(e.a[3:0], rd);
				check_word("prdata", e.exp, rd);
			end
			default: begin
				waited = 0;
				while (arcade_input_top_inst.not_empty && waited < 20) begin
					next_cycle();
					waited++;
				end
				if (arcade_input_top_inst.not_empty) begin
					$display("key event queue still not empty after 20 cycles");
					entry_ok = 1'b0;
				end
				check_inputs("game_inputs", m_out, game_inputs);
			end
		endcase
	endtask

	initial begin
		int gap;
		rst_n       = 1'b0;
		key_strobe  = 1'b0;
		key_code    = '0;
		key_pressed = 1'b0;
		joystick_0  = '0;
		joystick_1  = '0;
		psel        = 1'b0;
		penable     = 1'b0;
		pwrite      = 1'b0;
		paddr       = '0;
		pwdata      = '0;
		m_held      = '0;
		m_joy0      = '0;
		m_joy1      = '0;
		m_ctrl      = '0;
		m_dip       = '0;
		m_out       = '0;
		n_pass      = 0;
		n_fail      = 0;
		lfsr        = 16'd13;
		build_table();
		table_len = table_q.size();
		repeat (8) @(posedge clk_mist);
		#1 rst_n = 1'b1;
		next_cycle();
		foreach (table_q[i]) begin
			entry_ok = 1'b1;
			run_entry(table_q[i]);
			if (entry_ok) begin
				n_pass++;
				$display("entry %0d %s ok", i, table_q[i].kind.name());
			end else begin
				n_fail++;
				$display("entry %0d %s mismatch", i, table_q[i].kind.name());
			end
			gap = {lfsr_bit(), lfsr_bit()}; // 0 to 3 idle cycles
			repeat (gap) next_cycle();
		end
		$display("%0d entries ok, %0d entries wrong", n_pass, n_fail);
		if (n_fail == 0)
			$display("test passed");
		else
			$display("test failed");
		$finish;
	end

	// watchdog
	initial begin
		wait (table_len > 0);
		repeat (table_len * 40) @(posedge clk_mist);
		$display("run timed out after %0d cycles", table_len * 40);
		$display("test failed");
		$finish;
	end

endmodule

/* sources.f */
logic/arcade_input_pkg.sv
logic/key_event_decoder.sv
logic/key_event_fifo.sv
logic/control_mapper.sv
logic/core_config_regs.sv
logic/arcade_input_top.sv
dv/arcade_input_tb.sv

/* Bender.yml */
package:
  name: arcade_input

sources:
  - logic/arcade_input_pkg.sv
  - logic/key_event_decoder.sv
  - logic/key_event_fifo.sv
  - logic/control_mapper.sv
  - logic/core_config_regs.sv
  - logic/arcade_input_top.sv
  - target: test
    files:
      - dv/arcade_input_tb.sv
